// ==== conv_pkg.sv ====
`default_nettype none

package conv_pkg;

	////////////////////
	// Widths

	// One weight or one pixel channel value
	localparam int data_width = 16;

	// Sum of two 16x16 products fits in 34 bits
	localparam int acc_width = 34;

	////////////////////
	// Layer shape

	localparam int in_ch  = 2;
	localparam int out_ch = 2;

	// 2x2x1x1 kernel
	localparam int weight_num = in_ch * out_ch;

	// log2 of weight_num, used by the delay FIFO
	localparam int pointer_width = 2;

	////////////////////
	// Data types

	// Signed fixed point word
	typedef logic signed [data_width-1:0] data_t;

	// Channel 0 in the low word
	typedef data_t [in_ch-1:0] pixel_t;

	// Index is out channel * in_ch + in channel
	typedef data_t [weight_num-1:0] weight_set_t;

	// One result word per output channel
	typedef logic [out_ch-1:0][acc_width-1:0] result_t;

endpackage

`default_nettype wire

// ==== cnn_fifo_delay.sv ====
`timescale 1ns/100ps
`default_nettype none

module cnn_fifo_delay
	import conv_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  write,
	input  logic  read,
	input  data_t data_in,
	output data_t data_out,
	output logic  full,
	output logic  empty
);

	////////////////////
	// Storage and pointers

	// Circular buffer, one entry per weight
	data_t mem [weight_num];

	logic [pointer_width-1:0] wr_ptr;
	logic [pointer_width-1:0] rd_ptr;

	// One extra bit so a full buffer differs from an empty one
	logic [pointer_width:0] count;

	logic do_write;
	logic do_read;

	// Write on full and read on empty are dropped
	assign do_write = write & ~full;
	assign do_read  = read & ~empty;

	assign full  = (count == (pointer_width + 1)'(weight_num));
	assign empty = (count == '0);

	////////////////////
	// Control

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave count alone
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////
	// Data path

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= data_in;
		end
		// Registered read port, word shows up the cycle after the pop
		if (do_read) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

// ==== conv_1x1_buffer_weights.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_1x1_buffer_weights
	import conv_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  valid_in,
	input  data_t in,
	input  logic  load_weights,
	output data_t out_buffer_weight,
	output logic  full,
	output logic  valid_out
);

	////////////////////
	// Input register stage

	data_t in_reg;
	logic  in_valid_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			in_valid_reg <= 1'b0;
		end else begin
			in_valid_reg <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		in_reg <= in;
	end

	////////////////////
	// Delay FIFO

	// Registered weight goes straight in, bank pops it
	cnn_fifo_delay i_fifo (
		.clk      (clk),
		.reset    (reset),
		.write    (in_valid_reg),
		.read     (load_weights),
		.data_in  (in_reg),
		.data_out (out_buffer_weight),
		.full     (full),
		.empty    ()
	);

	// Sticky once the first pop has happened
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (load_weights) begin
			valid_out <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== conv_1x1_weight_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_1x1_weight_bank
	import conv_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  data_t       buf_data,
	input  logic        buf_full,
	output logic        load_weights,
	output weight_set_t weights,
	output logic        weights_ready
);

	localparam logic [pointer_width-1:0] last_idx = pointer_width'(weight_num - 1);

	////////////////////
	// Read burst

	// High for the remaining cycles of a burst
	logic busy;
	logic reading;

	// Index of the word being popped this cycle
	logic [pointer_width-1:0] rd_cnt;

	// Popped word lands on buf_data one cycle later
	logic                     cap_valid;
	logic [pointer_width-1:0] cap_idx;

	logic commit;

	// Burst starts in the same cycle full is seen
	assign reading      = busy | buf_full;
	assign load_weights = reading;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy      <= 1'b0;
			rd_cnt    <= '0;
			cap_valid <= 1'b0;
			cap_idx   <= '0;
		end else begin
			cap_valid <= reading;
			cap_idx   <= rd_cnt;
			if (reading) begin
				// Counter wraps back to 0 after the last pop
				rd_cnt <= rd_cnt + 1'b1;
				busy   <= (rd_cnt != last_idx);
			end
		end
	end

	////////////////////
	// Shadow and active sets

	weight_set_t shadow;
	weight_set_t shadow_next;

	// Shadow with the word arriving this cycle merged in
	always_comb begin
		shadow_next = shadow;
		if (cap_valid) begin
			shadow_next[cap_idx] = buf_data;
		end
	end

	// Last word of the burst completes the set
	assign commit = cap_valid & (cap_idx == last_idx);

	always_ff @(posedge clk) begin
		if (cap_valid) begin
			shadow <= shadow_next;
		end
		// Whole set swaps in one edge, PEs never see a partial reload
		if (commit) begin
			weights <= shadow_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			weights_ready <= 1'b0;
		end else if (commit) begin
			weights_ready <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== conv_1x1_pe.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_1x1_pe
	import conv_pkg::*;
#(
	// Output channel served by this PE
	parameter int channel = 0
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        pixel_valid,
	input  pixel_t                      pixel_in,
	input  weight_set_t                 weights,
	input  logic                        weights_ready,
	output logic signed [acc_width-1:0] result,
	output logic                        result_valid
);

	////////////////////
	// Stage 1 products

	logic signed [2*data_width-1:0] prod [in_ch];
	logic                           prod_valid;
	logic                           accept;

	// Pixels before the first weight set are dropped
	assign accept = pixel_valid & weights_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
		end else begin
			prod_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			for (int i = 0; i < in_ch; i++) begin
				// Weight index out channel * in_ch + in channel
				// Both factors sign extended to the product width
				prod[i] <= (2*data_width)'(pixel_in[i])
					* (2*data_width)'(weights[channel*in_ch + i]);
			end
		end
	end

	////////////////////
	// Stage 2 sum

	logic signed [acc_width-1:0] sum;

	// Products sign extended to full width before adding
	always_comb begin
		sum = '0;
		for (int i = 0; i < in_ch; i++) begin
			sum = sum + acc_width'(prod[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= prod_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid) begin
			result <= sum;
		end
	end

endmodule

`default_nettype wire

// ==== conv_1x1_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_1x1_core
	import conv_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    weight_valid,
	input  data_t   weight_in,
	input  logic    pixel_valid,
	input  pixel_t  pixel_in,
	output logic    weights_ready,
	output logic    result_valid,
	output result_t result_out
);

	////////////////////
	// Internal wires

	// Buffer to bank
	data_t buf_data;
	logic  buf_full;

	// Bank back to buffer
	logic load_weights;

	// Bank to both PEs
	weight_set_t weights;

	// One word per output channel
	logic signed [acc_width-1:0] pe_result_0;
	logic signed [acc_width-1:0] pe_result_1;

	////////////////////
	// Weight load path

	conv_1x1_buffer_weights i_buffer_weights (
		.clk               (clk),
		.reset             (reset),
		.valid_in          (weight_valid),
		.in                (weight_in),
		.load_weights      (load_weights),
		.out_buffer_weight (buf_data),
		.full              (buf_full),
		.valid_out         ()
	);

	conv_1x1_weight_bank i_weight_bank (
		.clk           (clk),
		.reset         (reset),
		.buf_data      (buf_data),
		.buf_full      (buf_full),
		.load_weights  (load_weights),
		.weights       (weights),
		.weights_ready (weights_ready)
	);

	////////////////////
	// Compute path

	// Both PEs run in lockstep, so channel 0 valid covers both
	conv_1x1_pe #(
		.channel (0)
	) i_pe_0 (
		.clk           (clk),
		.reset         (reset),
		.pixel_valid   (pixel_valid),
		.pixel_in      (pixel_in),
		.weights       (weights),
		.weights_ready (weights_ready),
		.result        (pe_result_0),
		.result_valid  (result_valid)
	);

	conv_1x1_pe #(
		.channel (1)
	) i_pe_1 (
		.clk           (clk),
		.reset         (reset),
		.pixel_valid   (pixel_valid),
		.pixel_in      (pixel_in),
		.weights       (weights),
		.weights_ready (weights_ready),
		.result        (pe_result_1),
		.result_valid  ()
	);

	// Channel 0 in the low word
	assign result_out = {pe_result_1, pe_result_0};

endmodule

`default_nettype wire

// ==== tb_conv_1x1_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_conv_1x1_core
	import conv_pkg::*;
();

	////////////////////
	// DUT and clock

	logic    clk;
	logic    reset;
	logic    weight_valid;
	data_t   weight_in;
	logic    pixel_valid;
	pixel_t  pixel_in;
	logic    weights_ready;
	logic    result_valid;
	result_t result_out;

	conv_1x1_core i_conv_1x1_core (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.weight_in     (weight_in),
		.pixel_valid   (pixel_valid),
		.pixel_in      (pixel_in),
		.weights_ready (weights_ready),
		.result_valid  (result_valid),
		.result_out    (result_out)
	);

	// 4 ns period
	always #2 clk = ~clk;

	////////////////////
	// Model state

	integer      seed;
	int          cycle;
	int          errors;
	int          test_errors;
	int          tests_run;
	int          tests_failed;
	int          results_seen;
	string       test_name;
	// Set in use, set waiting for commit, set being collected
	weight_set_t active_set;
	weight_set_t pending_set;
	weight_set_t stage_set;
	int          stage_count;
	logic        model_ready;
	logic        pending;
	int          pending_step;
	// Expected words and the cycle each one is due
	longint      exp_0[$];
	longint      exp_1[$];
	int          exp_due[$];

	// Output channel o, full width sum over input channels
	function automatic longint expected_sum(pixel_t px, weight_set_t w, int o);
		longint acc;
		acc = 0;
		for (int i = 0; i < in_ch; i++) begin
			acc += longint'(px[i]) * longint'(w[o*in_ch + i]);
		end
		return acc;
	endfunction

	function automatic data_t random_word();
		return data_t'($random(seed));
	endfunction

	function automatic pixel_t random_pixel();
		pixel_t p;
		for (int i = 0; i < in_ch; i++) begin
			p[i] = random_word();
		end
		return p;
	endfunction

	function automatic weight_set_t random_set();
		weight_set_t w;
		for (int k = 0; k < weight_num; k++) begin
			w[k] = random_word();
		end
		return w;
	endfunction

	task automatic report_mismatch(string what, longint exp_val, longint act_val);
		$display("** Error %s %s: expected %0d, actual %0d", test_name, what, exp_val, act_val);
		errors++;
	endtask

	task automatic fail(string msg);
		$display("** Error %s: %s", test_name, msg);
		errors++;
	endtask

	////////////////////
	// Cycle stepping

	// Advance one clock, sample 1 ns after the edge, check any result
	task automatic step();
		longint got_0;
		longint got_1;
		@(posedge clk);
		#1;
		cycle++;
		// Commit lands 7 cycles after the last weight strobe
		if (pending && cycle >= pending_step) begin
			active_set  = pending_set;
			model_ready = 1'b1;
			pending     = 1'b0;
		end
		got_0 = longint'($signed(result_out[0]));
		got_1 = longint'($signed(result_out[1]));
		if (result_valid) begin
			results_seen++;
			if (exp_due.size() == 0) begin
				fail("result_valid high with no pixel in flight");
			end else begin
				if (exp_due[0] != cycle) begin
					report_mismatch("result cycle", longint'(exp_due[0]), longint'(cycle));
				end
				if (exp_0[0] != got_0) begin
					report_mismatch("channel 0", exp_0[0], got_0);
				end
				if (exp_1[0] != got_1) begin
					report_mismatch("channel 1", exp_1[0], got_1);
				end
				void'(exp_due.pop_front());
				void'(exp_0.pop_front());
				void'(exp_1.pop_front());
			end
		end else if (exp_due.size() != 0 && exp_due[0] < cycle) begin
			fail("result_valid missing for an accepted pixel");
			void'(exp_due.pop_front());
			void'(exp_0.pop_front());
			void'(exp_1.pop_front());
		end
	endtask

	// Drive one cycle of inputs, update the model, then step
	task automatic cycle_drive(logic wv, data_t w, logic pv, pixel_t px);
		weight_valid = wv;
		weight_in    = w;
		pixel_valid  = pv;
		pixel_in     = px;
		// Only pixels seen after the first commit make results
		if (pv && model_ready) begin
			exp_0.push_back(expected_sum(px, active_set, 0));
			exp_1.push_back(expected_sum(px, active_set, 1));
			exp_due.push_back(cycle + 2);
		end
		if (wv) begin
			stage_set[stage_count] = w;
			stage_count++;
			if (stage_count == weight_num) begin
				pending_set  = stage_set;
				pending      = 1'b1;
				pending_step = cycle + 7;
				stage_count  = 0;
			end
		end
		step();
	endtask

	task automatic idle();
		cycle_drive(1'b0, '0, 1'b0, '0);
	endtask

	// Four weights back to back, pixels optional in the same cycles
	task automatic send_group(weight_set_t w, logic with_pixels);
		for (int k = 0; k < weight_num; k++) begin
			cycle_drive(1'b1, w[k], with_pixels, random_pixel());
		end
	endtask

	task automatic single_pixel(pixel_t p);
		int waited;
		waited = 0;
		cycle_drive(1'b0, '0, 1'b1, p);
		while (!result_valid && waited < 10) begin
			idle();
			waited++;
		end
		if (!result_valid) begin
			fail("no result for a single pixel");
		end
		idle();
	endtask

	// Let queued results come out
	task automatic drain();
		int waited;
		waited = 0;
		while (exp_due.size() != 0 && waited < 20) begin
			idle();
			waited++;
		end
		if (exp_due.size() != 0) begin
			fail("expected results never arrived");
		end
	endtask

	task automatic start_test(string name);
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors != test_errors) begin
			tests_failed++;
			$display("%s: FAIL (%0d errors)", test_name, errors - test_errors);
		end else begin
			$display("%s: ok", test_name);
		end
	endtask

	////////////////////
	// Test sequence

	initial begin
		weight_set_t extreme;
		pixel_t      corner[4];
		int          waited;
		int          last_strobe;
		int          seen_start;
		clk          = 1'b0;
		reset        = 1'b1;
		weight_valid = 1'b0;
		weight_in    = '0;
		pixel_valid  = 1'b0;
		pixel_in     = '0;
		seed         = 9;
		cycle        = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		results_seen = 0;
		stage_count  = 0;
		model_ready  = 1'b0;
		pending      = 1'b0;
		pending_step = 0;
		active_set   = '0;
		pending_set  = '0;
		stage_set    = '0;
		test_name    = "reset";
		repeat (10) step();
		reset = 1'b0;

		// Pixels before any weights must be dropped
		start_test("no_weights");
		for (int n = 0; n < 20; n++) begin
			cycle_drive(1'b0, '0, (n < 8), random_pixel());
			if (result_valid) begin
				fail("result_valid high before any weights");
			end
			if (weights_ready) begin
				fail("weights_ready high before any weights");
			end
		end
		end_test();

		start_test("weight_load");
		send_group(random_set(), 1'b0);
		last_strobe = cycle - 1;
		waited = 0;
		while (!weights_ready && waited < 20) begin
			idle();
			waited++;
		end
		if (!weights_ready) begin
			fail("weights_ready never rose after a weight group");
		end else if (cycle - last_strobe > 7) begin
			report_mismatch("ready cycle", longint'(last_strobe + 7), longint'(cycle));
		end
		end_test();

		// Corners of the signed range
		start_test("single_pixels");
		corner[0] = {16'sh8000, 16'sh8000};
		corner[1] = {16'sh7fff, 16'sh7fff};
		corner[2] = {16'sh7fff, 16'sh8000};
		corner[3] = {16'sh0000, 16'shffff};
		for (int n = 0; n < 4; n++) begin
			single_pixel(corner[n]);
			single_pixel(random_pixel());
		end
		// Extreme weights, commit is 7 cycles after the group
		extreme = {16'sh8000, 16'sh7fff, 16'sh8000, 16'sh8000};
		send_group(extreme, 1'b0);
		repeat (6) idle();
		for (int n = 0; n < 4; n++) begin
			single_pixel(corner[n]);
		end
		end_test();

		start_test("pixel_burst");
		seen_start = results_seen;
		for (int n = 0; n < 50; n++) begin
			cycle_drive(1'b0, '0, 1'b1, random_pixel());
		end
		drain();
		if (results_seen - seen_start != 50) begin
			report_mismatch("result count", 64'sd50, longint'(results_seen - seen_start));
		end
		end_test();

		// Old set up to the last weight, quiet gap, then new set
		start_test("weight_reload");
		for (int n = 0; n < 8; n++) begin
			cycle_drive(1'b0, '0, 1'b1, random_pixel());
		end
		send_group(random_set(), 1'b1);
		repeat (6) idle();
		for (int n = 0; n < 12; n++) begin
			cycle_drive(1'b0, '0, 1'b1, random_pixel());
		end
		drain();
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
conv_pkg.sv
cnn_fifo_delay.sv
conv_1x1_buffer_weights.sv
conv_1x1_weight_bank.sv
conv_1x1_pe.sv
conv_1x1_core.sv
tb_conv_1x1_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the conv_1x1_core testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --timescale 1ns/100ps -f files.f \
	--top-module tb_conv_1x1_core --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1
